//--- periph_bus.f
+incdir+logic
logic/periph_pkg.sv
logic/sysbus_bridge.sv
logic/gp_regs.sv
logic/uart_tx_fifo.sv
logic/periph_top.sv
verification/periph_checker.sv
verification/periph_tb.sv

//--- Makefile
SIM      := verilator
TOP      := periph_tb
FILELIST := periph_bus.f
FLAGS    := --binary --timing --assert -Wno-fatal
BIN      := obj_dir/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- verification/periph_tb.sv
// =========================================================================
// testbench for the peripheral subsystem with bus tasks, a UART line
// monitor and a directed sequence over registers, GPIO and transmitter
// =========================================================================

`timescale 1ns/1ps

`include "periph_bus_cfg.svh"

module periph_tb;

    localparam int                   TIMEOUT    = 20000;
    localparam logic [`PB_ADR_W-1:0] GPREG_BASE = 24'h80_0100;
    localparam logic [`PB_ADR_W-1:0] UART_BASE  = 24'h80_0200;

    logic                  clk;
    logic                  rst_i;
    periph_pkg::sys_req_t  sys_req;
    periph_pkg::sys_rsp_t  sys_rsp;
    logic [`PB_GPIO_W-1:0] gpio_read;
    logic [`PB_GPIO_W-1:0] gpio_dir;
    logic [`PB_GPIO_W-1:0] gpio_write;
    logic                  uart_tx;

    int          errors;
    int          checks;
    int          tests;
    int          err_base;
    int          bus_latency;
    bit          timed_out;
    int unsigned prescale;
    logic [7:0]  rx_q[$];
    logic [7:0]  exp_q[$];

    periph_top periph_top_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .sys_req_i    (sys_req),
        .sys_rsp_o    (sys_rsp),
        .gpio_read_i  (gpio_read),
        .gpio_dir_o   (gpio_dir),
        .gpio_write_o (gpio_write),
        .uart_tx_o    (uart_tx)
    );

    always #50 clk = ~clk;

    // =====================================================================
    // helpers
    // =====================================================================
    function automatic logic [`PB_ADR_W-1:0] reg_adr(input periph_pkg::reg_idx_e idx);
        return GPREG_BASE | (`PB_ADR_W'(idx) << 2);
    endfunction

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        if (timed_out) return;
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("[%0d] %s: %0d errors", tests, name, errors - err_base);
        err_base = errors;
    endtask

    // strobe stays up through the acknowledge cycle
    task automatic bus_access(input logic [`PB_ADR_W-1:0] adr, input logic we,
                              input logic [3:0] sel, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int n;
        rdat = '0;
        if (timed_out) return;
        sys_req.adr  = adr;
        sys_req.wdat = wdat;
        sys_req.we   = we;
        sys_req.sel  = sel;
        sys_req.stb  = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!sys_rsp.ack && n < TIMEOUT);
        if (!sys_rsp.ack) begin
            $display("timeout: no bus acknowledge for address %h", adr);
            timed_out = 1'b1;
        end
        bus_latency = n;
        rdat = sys_rsp.rdat;
        @(posedge clk);
        #1;
        sys_req.stb = 1'b0;
    endtask

    task automatic bus_write(input logic [`PB_ADR_W-1:0] adr, input logic [3:0] sel,
                             input logic [31:0] wdat);
        logic [31:0] rdat_drop;
        bus_access(adr, 1'b1, sel, wdat, rdat_drop);
    endtask

    task automatic bus_read(input logic [`PB_ADR_W-1:0] adr, output logic [31:0] rdat);
        bus_access(adr, 1'b0, 4'hf, 32'h0, rdat);
    endtask

    task automatic wait_rx(input int count);
        int n;
        n = 0;
        while (rx_q.size() < count && n < TIMEOUT && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rx_q.size() < count && !timed_out) begin
            $display("timeout: only %0d of %0d UART bytes arrived", rx_q.size(), count);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_tx_idle(output logic [31:0] status);
        int n;
        n = 0;
        bus_read(reg_adr(periph_pkg::REG_UART_STATUS), status);
        while (!status[16] && n < TIMEOUT && !timed_out) begin
            bus_read(reg_adr(periph_pkg::REG_UART_STATUS), status);
            n++;
        end
        if (!status[16] && !timed_out) begin
            $display("timeout: UART transmitter never went idle");
            timed_out = 1'b1;
        end
    endtask

    task automatic compare_rx(input string what);
        expect_eq(rx_q.size(), exp_q.size(), {what, " byte count"});
        foreach (rx_q[i]) begin
            if (i < exp_q.size()) begin
                expect_eq(rx_q[i], exp_q[i], {what, " byte"});
            end
        end
    endtask

    // =====================================================================
    // UART line monitor, samples mid-bit
    // =====================================================================
    always begin : line_monitor
        logic [7:0] data;
        @(posedge clk);
        #1;
        if (!rst_i && !uart_tx) begin
            repeat (prescale / 2) @(posedge clk);
            #1;
            expect_eq(uart_tx, 1'b0, "start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (prescale + 1) @(posedge clk);
                #1;
                data[i] = uart_tx;
            end
            repeat (prescale + 1) @(posedge clk);
            #1;
            expect_eq(uart_tx, 1'b1, "stop bit");
            rx_q.push_back(data);
        end
    end

    // =====================================================================
    // test sequence
    // =====================================================================
    initial begin
        logic [31:0] rdat;
        logic [31:0] wdat;
        logic [31:0] wdat2;
        logic [3:0]  sel;
        int          n1;
        int          max_lat;
        void'($urandom(32'h9c89));
        clk       = 1'b0;
        rst_i     = 1'b1;
        sys_req   = '0;
        gpio_read = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        err_base  = 0;
        timed_out = 1'b0;
        prescale  = `PB_PRESCALER_RST;
        repeat (10) @(posedge clk);
        #1;
        rst_i = 1'b0;

        for (int k = 0; k < 4; k++) begin
            wdat  = $urandom;
            wdat2 = $urandom;
            bus_write(reg_adr(periph_pkg::REG_SCRATCH), 4'hf, wdat);
            bus_write(reg_adr(periph_pkg::REG_BOOTVEC), 4'hf, wdat2);
            bus_read(reg_adr(periph_pkg::REG_SCRATCH), rdat);
            expect_eq(rdat, wdat, "scratch readback");
            expect_eq(bus_latency, 3, "register acknowledge latency");
            bus_read(reg_adr(periph_pkg::REG_BOOTVEC), rdat);
            expect_eq(rdat, wdat2 & 32'h00ff_ffff, "boot vector readback");
        end
        end_test("scratch and boot vector");

        wdat  = $urandom;
        wdat2 = $urandom;
        bus_write(reg_adr(periph_pkg::REG_GPIO_DIR), 4'hf, wdat);
        expect_eq(gpio_dir, wdat & 32'hffff, "gpio direction pins");
        bus_write(reg_adr(periph_pkg::REG_GPIO_WRITE), 4'hf, wdat2);
        expect_eq(gpio_write, wdat2 & 32'hffff, "gpio output pins");
        gpio_read = 16'($urandom);
        bus_read(reg_adr(periph_pkg::REG_GPIO_READ), rdat);
        expect_eq(rdat, {16'h0, gpio_read}, "gpio input mirror");
        bus_write(reg_adr(periph_pkg::REG_GPIO_READ), 4'hf, ~rdat);
        bus_read(reg_adr(periph_pkg::REG_GPIO_READ), rdat);
        expect_eq(rdat, {16'h0, gpio_read}, "gpio input after write");
        expect_eq(gpio_dir, wdat & 32'hffff, "gpio direction after input write");
        expect_eq(gpio_write, wdat2 & 32'hffff, "gpio output after input write");
        end_test("gpio");

        // line is idle here, so the monitor can switch rate
        prescale = 2 + ($urandom % 8);
        bus_write(reg_adr(periph_pkg::REG_UART_PRESCALER), 4'hf, prescale);
        bus_read(reg_adr(periph_pkg::REG_UART_PRESCALER), rdat);
        expect_eq(rdat, prescale, "prescaler readback");
        rx_q.delete();
        exp_q.delete();
        for (int s = 0; s < 3; s++) begin
            sel  = (s == 0) ? 4'b0001 : (s == 1) ? 4'b0011 : 4'b1111;
            wdat = $urandom;
            bus_write(UART_BASE, sel, wdat);
            for (int l = 0; l < 4; l++) begin
                if (sel[l]) begin
                    exp_q.push_back(wdat[l*8 +: 8]);
                end
            end
            wait_rx(exp_q.size());
        end
        wait_tx_idle(rdat);
        compare_rx("lane frames");
        end_test("uart byte lanes");

        rx_q.delete();
        exp_q.delete();
        max_lat = 0;
        for (int w = 0; w < 5; w++) begin
            wdat = $urandom;
            bus_write(UART_BASE, 4'hf, wdat);
            if (bus_latency > max_lat) begin
                max_lat = bus_latency;
            end
            for (int l = 0; l < 4; l++) begin
                exp_q.push_back(wdat[l*8 +: 8]);
            end
        end
        bus_read(reg_adr(periph_pkg::REG_UART_STATUS), rdat);
        expect_eq(rdat[17], 1'b1, "full flag during burst");
        expect_eq(max_lat > 10 * (prescale + 1), 1'b1, "burst write stalled for a frame");
        wait_rx(exp_q.size());
        wait_tx_idle(rdat);
        expect_eq(rdat, 32'h0001_0000, "status after burst");
        compare_rx("burst");
        end_test("uart burst");

        rx_q.delete();
        exp_q.delete();
        for (int w = 0; w < 4; w++) begin
            wdat = $urandom;
            bus_write(UART_BASE, 4'hf, wdat);
            for (int l = 0; l < 4; l++) begin
                exp_q.push_back(wdat[l*8 +: 8]);
            end
        end
        bus_write(reg_adr(periph_pkg::REG_UART_STATUS), 4'hf, 32'h8000_0000);
        n1 = rx_q.size();
        wait_tx_idle(rdat);
        expect_eq(rdat, 32'h0001_0000, "status after clear");
        // quiet stretch of several frame times
        repeat (40 * (prescale + 1)) @(posedge clk);
        #1;
        expect_eq(rx_q.size() <= n1 + 1, 1'b1, "bytes arriving after clear");
        foreach (rx_q[i]) begin
            expect_eq(rx_q[i], exp_q[i], "byte sent before clear");
        end
        end_test("uart clear");

        bus_read(24'h00_0100, rdat);
        expect_eq(rdat, 32'h0, "read outside peripheral region");
        expect_eq(bus_latency, 1, "unmapped acknowledge latency");
        bus_read(24'h80_0000, rdat);
        expect_eq(rdat, 32'h0, "read with no page bit");
        bus_read(24'h80_0300, rdat);
        expect_eq(rdat, 32'h0, "read with both page bits");
        bus_read(UART_BASE, rdat);
        expect_eq(rdat, 32'h0, "uart page read");
        end_test("unmapped and uart reads");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verification/periph_checker.sv
// =========================================================================
// concurrent assertions on bus handshakes and transmitter state, bound
// into the subsystem top
// =========================================================================

`timescale 1ns/1ps

module periph_checker (
    input logic clk,
    input logic rst_i,
    input logic sys_stb,
    input logic sys_ack,
    input logic reg_stb,
    input logic reg_ack,
    input logic byte_stb,
    input logic byte_ack,
    input logic tx_full,
    input logic tx_empty,
    input logic tx
);

    // =====================================================================
    // handshakes
    // =====================================================================
    a_sys_ack_in_stb: assert property (@(posedge clk) disable iff (rst_i)
        sys_ack |-> sys_stb)
        else $error("system acknowledge seen without strobe");

    a_sys_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
        sys_ack |=> !sys_ack)
        else $error("system acknowledge held longer than one cycle");

    // a refused byte stays on offer until the transmitter takes it
    a_byte_hold: assert property (@(posedge clk) disable iff (rst_i)
        byte_stb && !byte_ack |=> byte_stb)
        else $error("byte strobe dropped before acknowledge");

    // register path: bridge sample, register ack, system ack
    a_reg_from_sys: assert property (@(posedge clk) disable iff (rst_i)
        $rose(reg_stb) |-> $past(sys_stb))
        else $error("register strobe raised without a system strobe");

    a_reg_ack_next: assert property (@(posedge clk) disable iff (rst_i)
        $rose(reg_stb) |=> reg_ack)
        else $error("register block did not acknowledge one cycle after strobe");

    a_sys_after_reg: assert property (@(posedge clk) disable iff (rst_i)
        reg_ack |=> sys_ack)
        else $error("system acknowledge did not follow register acknowledge");

    // =====================================================================
    // transmitter
    // =====================================================================
    a_full_empty: assert property (@(posedge clk) disable iff (rst_i)
        !(tx_full && tx_empty))
        else $error("transmit FIFO reports full and empty together");

    a_idle_line: assert property (@(posedge clk) disable iff (rst_i)
        tx_empty |-> tx)
        else $error("UART line low while transmitter is empty");

endmodule

bind periph_top periph_checker periph_checker_i (
    .clk      (clk),
    .rst_i    (rst_i),
    .sys_stb  (sys_req_i.stb),
    .sys_ack  (sys_rsp_o.ack),
    .reg_stb  (reg_req.stb),
    .reg_ack  (reg_rsp.ack),
    .byte_stb (byte_req.stb),
    .byte_ack (byte_ack),
    .tx_full  (tx_full),
    .tx_empty (tx_empty),
    .tx       (uart_tx_o)
);

//--- logic/periph_top.sv
// =========================================================================
// peripheral subsystem top with bridge, registers and UART transmitter
// =========================================================================

`timescale 1ns/1ps

`include "periph_bus_cfg.svh"

module periph_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  periph_pkg::sys_req_t  sys_req_i,
    output periph_pkg::sys_rsp_t  sys_rsp_o,
    input  logic [`PB_GPIO_W-1:0] gpio_read_i,
    output logic [`PB_GPIO_W-1:0] gpio_dir_o,
    output logic [`PB_GPIO_W-1:0] gpio_write_o,
    output logic                  uart_tx_o
);

    periph_pkg::reg_req_t  reg_req;
    periph_pkg::reg_rsp_t  reg_rsp;
    periph_pkg::byte_req_t byte_req;
    logic                  byte_ack;

    logic [`PB_SIZE_W-1:0] prescaler;
    logic                  tx_clear;
    logic [`PB_SIZE_W-1:0] tx_size;
    logic                  tx_full;
    logic                  tx_empty;

    sysbus_bridge sysbus_bridge_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .sys_req_i  (sys_req_i),
        .sys_rsp_o  (sys_rsp_o),
        .reg_req_o  (reg_req),
        .reg_rsp_i  (reg_rsp),
        .byte_req_o (byte_req),
        .byte_ack_i (byte_ack)
    );

    gp_regs gp_regs_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .reg_req_i    (reg_req),
        .reg_rsp_o    (reg_rsp),
        .gpio_read_i  (gpio_read_i),
        .gpio_dir_o   (gpio_dir_o),
        .gpio_write_o (gpio_write_o),
        .prescaler_o  (prescaler),
        .tx_clear_o   (tx_clear),
        .tx_size_i    (tx_size),
        .tx_full_i    (tx_full),
        .tx_empty_i   (tx_empty)
    );

    uart_tx_fifo uart_tx_fifo_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .byte_req_i  (byte_req),
        .byte_ack_o  (byte_ack),
        .prescaler_i (prescaler),
        .clear_i     (tx_clear),
        .size_o      (tx_size),
        .full_o      (tx_full),
        .empty_o     (tx_empty),
        .tx_o        (uart_tx_o)
    );

endmodule

//--- logic/uart_tx_fifo.sv
// =========================================================================
// UART transmitter with a byte FIFO, sends 8N1 frames where each bit
// lasts prescaler+1 clock cycles
// =========================================================================

`timescale 1ns/1ps

`include "periph_bus_cfg.svh"

module uart_tx_fifo (
    input  logic                  clk,
    input  logic                  rst_i,
    input  periph_pkg::byte_req_t byte_req_i,
    output logic                  byte_ack_o,
    input  logic [`PB_SIZE_W-1:0] prescaler_i,
    input  logic                  clear_i,
    output logic [`PB_SIZE_W-1:0] size_o,
    output logic                  full_o,
    output logic                  empty_o,
    output logic                  tx_o
);

    localparam int DEPTH      = `PB_FIFO_DEPTH;
    localparam int PTR_W      = $clog2(DEPTH);
    localparam int FRAME_BITS = 10;

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    logic                  busy_q;
    logic [`PB_SIZE_W-1:0] baud_q;
    logic [3:0]            bit_q;
    logic [FRAME_BITS-1:0] shift_q;
    logic                  bit_end;
    logic                  frame_end;

    // =====================================================================
    // FIFO
    // =====================================================================
    assign full_o = (count_q == (PTR_W+1)'(DEPTH));

    // no accept while a clear is in flight
    assign byte_ack_o = byte_req_i.stb && !full_o && !clear_i;
    assign push       = byte_ack_o && byte_req_i.we;

    // next byte goes out as soon as the line frees up
    assign pop = (!busy_q || frame_end) && (count_q != '0) && !clear_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= byte_req_i.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            rd_ptr_q <= wr_ptr_q;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    // size counts the byte on the line as well
    assign size_o  = `PB_SIZE_W'(count_q) + `PB_SIZE_W'(busy_q);
    assign empty_o = (count_q == '0) && !busy_q;

    // =====================================================================
    // serialiser
    // =====================================================================
    assign bit_end   = busy_q && (baud_q == '0);
    assign frame_end = bit_end && (bit_q == 4'(FRAME_BITS-1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            shift_q <= '1;
            bit_q   <= '0;
            baud_q  <= '0;
        end else if (pop) begin
            // stop, data lsb first, start
            busy_q  <= 1'b1;
            shift_q <= {1'b1, mem[rd_ptr_q], 1'b0};
            bit_q   <= '0;
            baud_q  <= prescaler_i;
        end else if (frame_end) begin
            busy_q <= 1'b0;
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
            bit_q   <= bit_q + 1'b1;
            baud_q  <= prescaler_i;
        end else if (busy_q) begin
            baud_q <= baud_q - 1'b1;
        end
    end

    // shifter holds all ones when idle
    assign tx_o = shift_q[0];

endmodule

//--- logic/gp_regs.sv
// =========================================================================
// general-purpose registers: scratch, boot vector, GPIO and UART control
// accessed word-wise through the register port of the bridge
// =========================================================================

`timescale 1ns/1ps

`include "periph_bus_cfg.svh"

module gp_regs (
    input  logic                 clk,
    input  logic                 rst_i,
    input  periph_pkg::reg_req_t reg_req_i,
    output periph_pkg::reg_rsp_t reg_rsp_o,
    input  logic [`PB_GPIO_W-1:0] gpio_read_i,
    output logic [`PB_GPIO_W-1:0] gpio_dir_o,
    output logic [`PB_GPIO_W-1:0] gpio_write_o,
    output logic [`PB_SIZE_W-1:0] prescaler_o,
    output logic                 tx_clear_o,
    input  logic [`PB_SIZE_W-1:0] tx_size_i,
    input  logic                 tx_full_i,
    input  logic                 tx_empty_i
);

    periph_pkg::reg_idx_e idx;

    logic                  access;
    logic                  wr_access;
    logic                  ack_q;
    logic [`PB_DAT_W-1:0]  rdat_q;
    logic [`PB_DAT_W-1:0]  rd_mux;
    logic [`PB_DAT_W-1:0]  status;
    logic                  tx_clear_q;

    logic [`PB_DAT_W-1:0]  scratch_q;
    logic [`PB_ADR_W-1:0]  bootvec_q;
    logic [`PB_GPIO_W-1:0] gpio_dir_q;
    logic [`PB_GPIO_W-1:0] gpio_write_q;
    logic [`PB_GPIO_W-1:0] gpio_read_q;
    logic [`PB_SIZE_W-1:0] prescaler_q;

    assign idx = periph_pkg::reg_idx_e'(reg_req_i.adr[`PB_REG_ADR_W-1:2]);

    // one access per strobe, the ack cycle blocks a repeat
    assign access    = reg_req_i.stb && !ack_q;
    assign wr_access = access && reg_req_i.we;

    // full in bit 17, empty in bit 16, size below
    assign status = {{(`PB_DAT_W-`PB_SIZE_W-2){1'b0}}, tx_full_i, tx_empty_i, tx_size_i};

    always_comb begin
        case (idx)
            periph_pkg::REG_SCRATCH:        rd_mux = scratch_q;
            periph_pkg::REG_BOOTVEC:        rd_mux = `PB_DAT_W'(bootvec_q);
            periph_pkg::REG_GPIO_DIR:       rd_mux = `PB_DAT_W'(gpio_dir_q);
            periph_pkg::REG_GPIO_WRITE:     rd_mux = `PB_DAT_W'(gpio_write_q);
            periph_pkg::REG_GPIO_READ:      rd_mux = `PB_DAT_W'(gpio_read_q);
            periph_pkg::REG_UART_PRESCALER: rd_mux = `PB_DAT_W'(prescaler_q);
            periph_pkg::REG_UART_STATUS:    rd_mux = status;
            default:                        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q        <= 1'b0;
            tx_clear_q   <= 1'b0;
            scratch_q    <= '0;
            bootvec_q    <= '0;
            gpio_dir_q   <= '0;
            gpio_write_q <= '0;
            gpio_read_q  <= '0;
            prescaler_q  <= `PB_SIZE_W'(`PB_PRESCALER_RST);
        end else begin
            ack_q       <= access;
            gpio_read_q <= gpio_read_i;
            tx_clear_q  <= wr_access && (idx == periph_pkg::REG_UART_STATUS)
                           && reg_req_i.wdat[`PB_DAT_W-1];
            if (wr_access) begin
                case (idx)
                    periph_pkg::REG_SCRATCH:        scratch_q    <= reg_req_i.wdat;
                    periph_pkg::REG_BOOTVEC:        bootvec_q    <= reg_req_i.wdat[`PB_ADR_W-1:0];
                    periph_pkg::REG_GPIO_DIR:       gpio_dir_q   <= reg_req_i.wdat[`PB_GPIO_W-1:0];
                    periph_pkg::REG_GPIO_WRITE:     gpio_write_q <= reg_req_i.wdat[`PB_GPIO_W-1:0];
                    periph_pkg::REG_UART_PRESCALER: prescaler_q  <= reg_req_i.wdat[`PB_SIZE_W-1:0];
                    // gpio read and status are read only
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= rd_mux;
        end
    end

    assign reg_rsp_o.rdat = rdat_q;
    assign reg_rsp_o.ack  = ack_q;

    assign gpio_dir_o   = gpio_dir_q;
    assign gpio_write_o = gpio_write_q;
    assign prescaler_o  = prescaler_q;
    assign tx_clear_o   = tx_clear_q;

endmodule

//--- logic/sysbus_bridge.sv
// =========================================================================
// system bus bridge that routes each access by page to the register block
// or splits a UART write into byte writes along the byte select
// =========================================================================

`timescale 1ns/1ps

`include "periph_bus_cfg.svh"

module sysbus_bridge (
    input  logic                  clk,
    input  logic                  rst_i,
    input  periph_pkg::sys_req_t  sys_req_i,
    output periph_pkg::sys_rsp_t  sys_rsp_o,
    output periph_pkg::reg_req_t  reg_req_o,
    input  periph_pkg::reg_rsp_t  reg_rsp_i,
    output periph_pkg::byte_req_t byte_req_o,
    input  logic                  byte_ack_i
);

    localparam int LANES  = `PB_DAT_W / 8;
    localparam int LANE_W = $clog2(LANES);

    periph_pkg::bridge_state_e state_q;

    logic [`PB_REG_ADR_W-1:0] reg_adr_q;
    logic [`PB_DAT_W-1:0]     wdat_q;
    logic                     we_q;
    logic [LANES-1:0]         sel_q;
    logic [LANE_W-1:0]        lane_q;
    logic                     reg_stb_q;
    logic [`PB_DAT_W-1:0]     rdat_q;

    logic             region_hit;
    logic             gpreg_hit;
    logic             uart_hit;
    logic [LANES-1:0] sel_from_lane;
    logic             last_lane;

    // =====================================================================
    // page decode on the live request
    // =====================================================================
    assign region_hit = sys_req_i.adr[`PB_REGION_BIT];
    assign gpreg_hit  = region_hit && sys_req_i.adr[`PB_PAGE_GPREG]
                        && !sys_req_i.adr[`PB_PAGE_UART];
    assign uart_hit   = region_hit && sys_req_i.adr[`PB_PAGE_UART]
                        && !sys_req_i.adr[`PB_PAGE_GPREG];

    // no selected lane left above the current one
    assign sel_from_lane = sel_q >> lane_q;
    assign last_lane     = (sel_from_lane[LANES-1:1] == '0);

    // =====================================================================
    // control FSM
    // =====================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= periph_pkg::IDLE;
            reg_stb_q <= 1'b0;
            lane_q    <= '0;
        end else begin
            case (state_q)
                periph_pkg::IDLE: begin
                    lane_q <= '0;
                    if (sys_req_i.stb) begin
                        if (gpreg_hit) begin
                            reg_stb_q <= 1'b1;
                            state_q   <= periph_pkg::REG_WAIT;
                        end else if (uart_hit && sys_req_i.we && (sys_req_i.sel != '0)) begin
                            state_q <= periph_pkg::BYTE_SEND;
                        end else begin
                            // unmapped, UART read or empty select
                            state_q <= periph_pkg::RESPOND;
                        end
                    end
                end
                periph_pkg::REG_WAIT: begin
                    if (reg_rsp_i.ack) begin
                        reg_stb_q <= 1'b0;
                        state_q   <= periph_pkg::RESPOND;
                    end
                end
                periph_pkg::BYTE_SEND: begin
                    // skip unselected lanes, hold a selected one until acked
                    if (!sel_q[lane_q] || byte_ack_i) begin
                        if (last_lane) begin
                            state_q <= periph_pkg::RESPOND;
                        end else begin
                            lane_q <= lane_q + 1'b1;
                        end
                    end
                end
                periph_pkg::RESPOND: begin
                    state_q <= periph_pkg::IDLE;
                end
                default: begin
                    state_q <= periph_pkg::IDLE;
                end
            endcase
        end
    end

    // latched request and returned read data
    always_ff @(posedge clk) begin
        if ((state_q == periph_pkg::IDLE) && sys_req_i.stb) begin
            reg_adr_q <= sys_req_i.adr[`PB_REG_ADR_W-1:0];
            wdat_q    <= sys_req_i.wdat;
            we_q      <= sys_req_i.we;
            sel_q     <= sys_req_i.sel;
            rdat_q    <= '0;
        end else if ((state_q == periph_pkg::REG_WAIT) && reg_rsp_i.ack) begin
            rdat_q <= reg_rsp_i.rdat;
        end
    end

    // =====================================================================
    // outputs
    // =====================================================================
    always_comb begin
        reg_req_o.adr  = reg_adr_q;
        reg_req_o.wdat = wdat_q;
        reg_req_o.we   = we_q;
        reg_req_o.stb  = reg_stb_q;

        byte_req_o.dat = wdat_q[lane_q*8 +: 8];
        byte_req_o.we  = we_q;
        byte_req_o.stb = (state_q == periph_pkg::BYTE_SEND) && sel_q[lane_q];

        sys_rsp_o.rdat = rdat_q;
        sys_rsp_o.ack  = (state_q == periph_pkg::RESPOND);
    end

endmodule

//--- logic/periph_pkg.sv
// =========================================================================
// bus request and response structs, register map and bridge states
// =========================================================================

`include "periph_bus_cfg.svh"

package periph_pkg;

    typedef struct packed {
        logic [`PB_ADR_W-1:0]   adr;
        logic [`PB_DAT_W-1:0]   wdat;
        logic                   we;
        logic [`PB_DAT_W/8-1:0] sel;
        logic                   stb;
    } sys_req_t;

    typedef struct packed {
        logic [`PB_DAT_W-1:0] rdat;
        logic                 ack;
    } sys_rsp_t;

    typedef struct packed {
        logic [`PB_REG_ADR_W-1:0] adr;
        logic [`PB_DAT_W-1:0]     wdat;
        logic                     we;
        logic                     stb;
    } reg_req_t;

    typedef struct packed {
        logic [`PB_DAT_W-1:0] rdat;
        logic                 ack;
    } reg_rsp_t;

    typedef struct packed {
        logic [7:0] dat;
        logic       we;
        logic       stb;
    } byte_req_t;

    // word index, byte address divided by 4
    typedef enum logic [`PB_REG_ADR_W-3:0] {
        REG_SCRATCH        = 0,
        REG_BOOTVEC        = 1,
        REG_GPIO_DIR       = 2,
        REG_GPIO_WRITE     = 3,
        REG_GPIO_READ      = 4,
        REG_UART_PRESCALER = 5,
        REG_UART_STATUS    = 6
    } reg_idx_e;

    typedef enum logic [1:0] {
        IDLE,
        REG_WAIT,
        BYTE_SEND,
        RESPOND
    } bridge_state_e;

endpackage

//--- logic/periph_bus_cfg.svh
// =========================================================================
// widths, FIFO depth, page decode bits and reset values of the subsystem
// included by the package and by each RTL module that sizes its ports
// =========================================================================

`ifndef PERIPH_BUS_CFG_SVH
`define PERIPH_BUS_CFG_SVH

// system bus
`define PB_ADR_W          24
`define PB_DAT_W          32
`define PB_REG_ADR_W      8

// peripherals
`define PB_GPIO_W         16
`define PB_FIFO_DEPTH     16
`define PB_SIZE_W         16
`define PB_PRESCALER_RST  7

// one-hot page bits inside the peripheral region
`define PB_REGION_BIT     23
`define PB_PAGE_GPREG     8
`define PB_PAGE_UART      9

`endif
